//--- src/soc_dbg_pkg.sv
`default_nettype none

package soc_dbg_pkg;

  // **************************************************************************
  // bus widths
  // **************************************************************************

  localparam int unsigned DATA_WIDTH = 32;
  localparam int unsigned ADDR_WIDTH = 12;

  // **************************************************************************
  // hart topology
  // **************************************************************************

  localparam int unsigned NR_HARTS       = 16;
  localparam int unsigned HART_IDX_WIDTH = $clog2(NR_HARTS);
  localparam int unsigned NB_CORES       = 1;
  localparam int unsigned HARTSEL_WIDTH  = 11;
  localparam logic [5:0]  FC_CLUSTER_ID  = 6'd0;
  localparam logic [3:0]  FC_CORE_ID     = 4'd0;

  // mhartid layout {cluster, 1'b0, core}
  typedef struct packed {
    logic [5:0] cluster_id;
    logic       zero;
    logic [3:0] core_id;
  } hart_fields_t;

  // same 11 bits, seen as index or as fields
  typedef union packed {
    logic [HARTSEL_WIDTH-1:0] raw;
    hart_fields_t             f;
  } hart_id_u;

  // one-hot set of harts that really exist
  function automatic logic [NR_HARTS-1:0] sel_harts_fx();
    hart_id_u            id;
    logic [NR_HARTS-1:0] mask;
    mask            = '0;
    id.f.cluster_id = FC_CLUSTER_ID;
    id.f.zero       = 1'b0;
    id.f.core_id    = FC_CORE_ID;
    // fabric controller hart
    if (id.raw < NR_HARTS) begin
      mask[id.raw[HART_IDX_WIDTH-1:0]] = 1'b1;
    end
    // cluster cores sit in cluster 0 as well
    for (int i = 0; i < NB_CORES; i++) begin
      id.f.core_id = 4'(i);
      if (id.raw < NR_HARTS) begin
        mask[id.raw[HART_IDX_WIDTH-1:0]] = 1'b1;
      end
    end
    return mask;
  endfunction

  localparam logic [NR_HARTS-1:0] SELECTABLE_HARTS = sel_harts_fx();

  // **************************************************************************
  // register map
  // **************************************************************************

  localparam logic [ADDR_WIDTH-1:0] ADDR_DMCONTROL = 12'h000;
  localparam logic [ADDR_WIDTH-1:0] ADDR_HARTINFO  = 12'h004;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DATA0     = 12'h008;
  localparam logic [ADDR_WIDTH-1:0] ADDR_DATA1     = 12'h00C;

  // dmcontrol fields
  localparam int unsigned DMCTRL_DMACTIVE_BIT = 0;
  localparam int unsigned DMCTRL_NDMRESET_BIT = 1;
  localparam int unsigned DMCTRL_HALTREQ_BIT  = 31;
  localparam int unsigned DMCTRL_HARTSEL_LSB  = 16;

  // hartinfo pieces
  localparam logic [3:0]  HARTINFO_NSCRATCH = 4'd2;
  localparam logic [3:0]  HARTINFO_DATASIZE = 4'd2;
  localparam logic [11:0] HARTINFO_DATAADDR = 12'h380;

  // zero1 | nscratch | zero0 | dataaccess | datasize | dataaddr
  localparam logic [DATA_WIDTH-1:0] HARTINFO_VALUE = {
    8'h00, HARTINFO_NSCRATCH, 3'b000, 1'b1, HARTINFO_DATASIZE, HARTINFO_DATAADDR
  };

  // **************************************************************************
  // watchdog
  // **************************************************************************

  localparam int unsigned WD_TIMEOUT   = 64;
  localparam int unsigned WD_CNT_WIDTH = $clog2(WD_TIMEOUT + 1);

endpackage

`default_nettype wire

//--- src/per_bus_if.sv
`timescale 1ns/1ns
`default_nettype none

// peripheral request bus, bridge to register slave
interface per_bus_if;

  // request side
  logic                               req;
  logic [soc_dbg_pkg::ADDR_WIDTH-1:0] addr;
  logic                               we;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] wdata;

  // grant and response side
  logic                               gnt;
  logic                               r_valid;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] r_rdata;

  modport master (
    output req, addr, we, wdata,
    input  gnt, r_valid, r_rdata
  );

  modport slave (
    input  req, addr, we, wdata,
    output gnt, r_valid, r_rdata
  );

endinterface

`default_nettype wire

//--- src/apb_to_per.sv
`timescale 1ns/1ns
`default_nettype none

module apb_to_per (
  input  logic                               s_soc_clk,
  input  logic                               s_soc_rstn,
  input  logic [soc_dbg_pkg::ADDR_WIDTH-1:0] paddr_i,
  input  logic [soc_dbg_pkg::DATA_WIDTH-1:0] pwdata_i,
  input  logic                               pwrite_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  output logic [soc_dbg_pkg::DATA_WIDTH-1:0] prdata_o,
  output logic                               pready_o,
  per_bus_if.master                          per
);

  // request already issued for this transfer
  logic pending_q;
  logic access;

  // access phase of an apb transfer
  assign access = psel_i & penable_i;

  // ****************************************************************************
  // request side
  // ****************************************************************************

  // one request, first access cycle only
  assign per.req   = access & ~pending_q;
  assign per.addr  = paddr_i;
  assign per.we    = pwrite_i;
  assign per.wdata = pwdata_i;

  // set on grant, dropped once the response is back
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      pending_q <= 1'b0;
    end else if (per.req && per.gnt) begin
      pending_q <= 1'b1;
    end else if (per.r_valid) begin
      pending_q <= 1'b0;
    end
  end

  // ****************************************************************************
  // response side
  // ****************************************************************************

  // r_valid comes one cycle after the grant, so the transfer
  // completes in the second access cycle
  assign pready_o = per.r_valid;
  assign prdata_o = per.r_rdata;

endmodule

`default_nettype wire

//--- src/dm_regs.sv
`timescale 1ns/1ns
`default_nettype none

module dm_regs (
  input  logic                             s_soc_clk,
  input  logic                             s_soc_rstn,
  per_bus_if.slave                         per,
  output logic                             dmactive_o,
  output logic                             ndmreset_o,
  output logic [soc_dbg_pkg::NR_HARTS-1:0] debug_req_o
);

  // dmcontrol fields
  logic                                  dmactive_q;
  logic                                  ndmreset_q;
  logic                                  haltreq_q;
  logic [soc_dbg_pkg::HARTSEL_WIDTH-1:0] hartsel_q;

  // scratch words
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] data0_q;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] data1_q;

  // response path
  logic                               r_valid_q;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] r_rdata_q;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] rdata_d;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] dmctrl_word;

  logic                  wr_en;
  soc_dbg_pkg::hart_id_u hartsel;

  // grant in the same cycle, always
  assign per.gnt = per.req;
  assign wr_en   = per.req & per.gnt & per.we;

  // ****************************************************************************
  // register writes
  // ****************************************************************************

  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      dmactive_q <= 1'b0;
      ndmreset_q <= 1'b0;
      haltreq_q  <= 1'b0;
      hartsel_q  <= '0;
    end else if (wr_en && per.addr == soc_dbg_pkg::ADDR_DMCONTROL) begin
      dmactive_q <= per.wdata[soc_dbg_pkg::DMCTRL_DMACTIVE_BIT];
      ndmreset_q <= per.wdata[soc_dbg_pkg::DMCTRL_NDMRESET_BIT];
      haltreq_q  <= per.wdata[soc_dbg_pkg::DMCTRL_HALTREQ_BIT];
      hartsel_q  <= per.wdata[soc_dbg_pkg::DMCTRL_HARTSEL_LSB +: soc_dbg_pkg::HARTSEL_WIDTH];
    end
  end

  // data0/data1, hartinfo is read only
  always_ff @(posedge s_soc_clk) begin
    if (wr_en && per.addr == soc_dbg_pkg::ADDR_DATA0) begin
      data0_q <= per.wdata;
    end
    if (wr_en && per.addr == soc_dbg_pkg::ADDR_DATA1) begin
      data1_q <= per.wdata;
    end
  end

  // ****************************************************************************
  // read mux and response
  // ****************************************************************************

  always_comb begin
    dmctrl_word = '0;
    dmctrl_word[soc_dbg_pkg::DMCTRL_DMACTIVE_BIT] = dmactive_q;
    dmctrl_word[soc_dbg_pkg::DMCTRL_NDMRESET_BIT] = ndmreset_q;
    dmctrl_word[soc_dbg_pkg::DMCTRL_HALTREQ_BIT]  = haltreq_q;
    dmctrl_word[soc_dbg_pkg::DMCTRL_HARTSEL_LSB +: soc_dbg_pkg::HARTSEL_WIDTH] = hartsel_q;
  end

  always_comb begin
    case (per.addr)
      soc_dbg_pkg::ADDR_DMCONTROL: rdata_d = dmctrl_word;
      soc_dbg_pkg::ADDR_HARTINFO:  rdata_d = soc_dbg_pkg::HARTINFO_VALUE;
      soc_dbg_pkg::ADDR_DATA0:     rdata_d = data0_q;
      soc_dbg_pkg::ADDR_DATA1:     rdata_d = data1_q;
      // unmapped reads as zero
      default:                     rdata_d = '0;
    endcase
  end

  // r_valid one cycle after every grant, reads and writes
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      r_valid_q <= 1'b0;
    end else begin
      r_valid_q <= per.req & per.gnt;
    end
  end

  always_ff @(posedge s_soc_clk) begin
    if (per.req && per.gnt) begin
      r_rdata_q <= rdata_d;
    end
  end

  assign per.r_valid = r_valid_q;
  assign per.r_rdata = r_rdata_q;

  // ****************************************************************************
  // halt requests
  // ****************************************************************************

  assign hartsel.raw = hartsel_q;

  // only the fc cluster, a clean zero bit and a selectable index
  always_comb begin
    debug_req_o = '0;
    if (haltreq_q && dmactive_q &&
        hartsel.f.cluster_id == soc_dbg_pkg::FC_CLUSTER_ID && !hartsel.f.zero &&
        hartsel.raw < soc_dbg_pkg::NR_HARTS) begin
      debug_req_o[hartsel.raw[soc_dbg_pkg::HART_IDX_WIDTH-1:0]] =
        soc_dbg_pkg::SELECTABLE_HARTS[hartsel.raw[soc_dbg_pkg::HART_IDX_WIDTH-1:0]];
    end
  end

  assign dmactive_o = dmactive_q;
  assign ndmreset_o = ndmreset_q;

endmodule

`default_nettype wire

//--- src/soc_watchdog.sv
`timescale 1ns/1ns
`default_nettype none

module soc_watchdog (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic kick_i,
  input  logic pause_i,
  output logic expired_o
);

  logic [soc_dbg_pkg::WD_CNT_WIDTH-1:0] cnt_q;
  logic                                 expired_q;

  // down counter, starts full out of reset
  // kick wins over pause
  always_ff @(posedge s_soc_clk or negedge s_soc_rstn) begin
    if (!s_soc_rstn) begin
      cnt_q     <= soc_dbg_pkg::WD_CNT_WIDTH'(soc_dbg_pkg::WD_TIMEOUT);
      expired_q <= 1'b0;
    end else if (kick_i) begin
      cnt_q <= soc_dbg_pkg::WD_CNT_WIDTH'(soc_dbg_pkg::WD_TIMEOUT);
    end else if (!pause_i && cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
      // last step to zero, flag stays until reset
      if (cnt_q == soc_dbg_pkg::WD_CNT_WIDTH'(1)) begin
        expired_q <= 1'b1;
      end
    end
  end

  assign expired_o = expired_q;

endmodule

`default_nettype wire

//--- src/soc_reset_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module soc_reset_ctrl (
  input  logic s_soc_clk,
  input  logic s_soc_rstn,
  input  logic wd_expired_i,
  input  logic ndmreset_i,
  output logic periph_rstn_o
);

  // combined clear, low while any source is active
  logic       clr_n;
  logic [1:0] sync_q;

  // both sources come straight from flops
  assign clr_n = s_soc_rstn & ~wd_expired_i & ~ndmreset_i;

  // assert at once, release after two edges
  always_ff @(posedge s_soc_clk or negedge clr_n) begin
    if (!clr_n) begin
      sync_q <= 2'b00;
    end else begin
      sync_q <= {sync_q[0], 1'b1};
    end
  end

  assign periph_rstn_o = sync_q[1];

endmodule

`default_nettype wire

//--- src/soc_debug_domain.sv
`timescale 1ns/1ns
`default_nettype none

module soc_debug_domain (
  input  logic                               s_soc_clk,
  input  logic                               s_soc_rstn,
  // apb port
  input  logic [soc_dbg_pkg::ADDR_WIDTH-1:0] paddr_i,
  input  logic [soc_dbg_pkg::DATA_WIDTH-1:0] pwdata_i,
  input  logic                               pwrite_i,
  input  logic                               psel_i,
  input  logic                               penable_i,
  output logic [soc_dbg_pkg::DATA_WIDTH-1:0] prdata_o,
  output logic                               pready_o,
  // watchdog and debug status
  input  logic                               wd_kick_i,
  output logic [soc_dbg_pkg::NR_HARTS-1:0]   debug_req_o,
  output logic                               dmactive_o,
  output logic                               wd_expired_o,
  output logic                               periph_rstn_o
);

  // ****************************************************************************
  // interconnect
  // ****************************************************************************

  logic s_ndmreset;

  per_bus_if per_bus ();

  // apb access phases to per requests
  apb_to_per apb_to_per_i (
    .s_soc_clk (s_soc_clk),
    .s_soc_rstn(s_soc_rstn),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .pwrite_i  (pwrite_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .prdata_o  (prdata_o),
    .pready_o  (pready_o),
    .per       (per_bus.master)
  );

  // debug module registers
  dm_regs dm_regs_i (
    .s_soc_clk  (s_soc_clk),
    .s_soc_rstn (s_soc_rstn),
    .per        (per_bus.slave),
    .dmactive_o (dmactive_o),
    .ndmreset_o (s_ndmreset),
    .debug_req_o(debug_req_o)
  );

  // paused for the whole debug session
  soc_watchdog soc_watchdog_i (
    .s_soc_clk (s_soc_clk),
    .s_soc_rstn(s_soc_rstn),
    .kick_i    (wd_kick_i),
    .pause_i   (dmactive_o),
    .expired_o (wd_expired_o)
  );

  // soc reset, watchdog, ndmreset
  soc_reset_ctrl soc_reset_ctrl_i (
    .s_soc_clk    (s_soc_clk),
    .s_soc_rstn   (s_soc_rstn),
    .wd_expired_i (wd_expired_o),
    .ndmreset_i   (s_ndmreset),
    .periph_rstn_o(periph_rstn_o)
  );

endmodule

`default_nettype wire

//--- verif/soc_debug_domain_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module soc_debug_domain_asserts (
  input logic                             s_soc_clk,
  input logic                             s_soc_rstn,
  input logic                             psel_i,
  input logic                             penable_i,
  input logic                             pready_o,
  input logic [soc_dbg_pkg::NR_HARTS-1:0] debug_req_o,
  input logic                             dmactive_o,
  input logic                             wd_expired_o,
  input logic                             periph_rstn_o
);

  // completion only inside an access phase
  a_pready_in_access: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    pready_o |-> (psel_i && penable_i))
    else $error("pready_o outside an APB access phase");

  // no halt request without an active debug module
  a_no_req_inactive: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    !dmactive_o |-> (debug_req_o == '0))
    else $error("debug_req_o set while dmactive_o is low");

  // expiry keeps the peripherals in reset
  a_wd_holds_reset: assert property (@(posedge s_soc_clk) disable iff (!s_soc_rstn)
    wd_expired_o |-> !periph_rstn_o)
    else $error("periph_rstn_o released after watchdog expiry");

endmodule

bind soc_debug_domain soc_debug_domain_asserts asserts0 (
  .s_soc_clk    (s_soc_clk),
  .s_soc_rstn   (s_soc_rstn),
  .psel_i       (psel_i),
  .penable_i    (penable_i),
  .pready_o     (pready_o),
  .debug_req_o  (debug_req_o),
  .dmactive_o   (dmactive_o),
  .wd_expired_o (wd_expired_o),
  .periph_rstn_o(periph_rstn_o)
);

`default_nettype wire

//--- verif/tb_soc_debug_domain.sv
`timescale 1ns/1ns
`default_nettype none

module tb_soc_debug_domain;

  logic                               s_soc_clk;
  logic                               s_soc_rstn;
  logic [soc_dbg_pkg::ADDR_WIDTH-1:0] paddr_i;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] pwdata_i;
  logic                               pwrite_i;
  logic                               psel_i;
  logic                               penable_i;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] prdata_o;
  logic                               pready_o;
  logic                               wd_kick_i;
  logic [soc_dbg_pkg::NR_HARTS-1:0]   debug_req_o;
  logic                               dmactive_o;
  logic                               wd_expired_o;
  logic                               periph_rstn_o;

  // model of the register file
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] dmctrl_m;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] data0_m;
  logic [soc_dbg_pkg::DATA_WIDTH-1:0] data1_m;
  logic                               mon_en;
  int unsigned                        n_checks;
  int unsigned                        n_errors;

  soc_debug_domain dut0 (.*);

  initial begin
    s_soc_clk = 1'b0;
    forever #20 s_soc_clk = ~s_soc_clk;
  end

  // ***************************************************************************
  // reference model
  // ***************************************************************************

  function automatic logic [soc_dbg_pkg::DATA_WIDTH-1:0] ctrl_word(
    input logic haltreq, input logic [10:0] hartsel, input logic ndmreset, input logic dmactive
  );
    logic [soc_dbg_pkg::DATA_WIDTH-1:0] w;
    w = '0;
    w[soc_dbg_pkg::DMCTRL_HALTREQ_BIT]                                = haltreq;
    w[soc_dbg_pkg::DMCTRL_HARTSEL_LSB +: soc_dbg_pkg::HARTSEL_WIDTH] = hartsel;
    w[soc_dbg_pkg::DMCTRL_NDMRESET_BIT]                               = ndmreset;
    w[soc_dbg_pkg::DMCTRL_DMACTIVE_BIT]                               = dmactive;
    return w;
  endfunction

  // expected read data, hartinfo is constant
  function automatic logic [soc_dbg_pkg::DATA_WIDTH-1:0] ref_read(
    input logic [soc_dbg_pkg::ADDR_WIDTH-1:0] addr
  );
    case (addr)
      soc_dbg_pkg::ADDR_DMCONTROL: return dmctrl_m;
      soc_dbg_pkg::ADDR_HARTINFO:  return soc_dbg_pkg::HARTINFO_VALUE;
      soc_dbg_pkg::ADDR_DATA0:     return data0_m;
      soc_dbg_pkg::ADDR_DATA1:     return data1_m;
      default:                     return '0;
    endcase
  endfunction

  // hart index is {cluster[5:0], 1'b0, core[3:0]}
  function automatic logic [soc_dbg_pkg::NR_HARTS-1:0] ref_debug_req(
    input logic [soc_dbg_pkg::DATA_WIDTH-1:0] ctrl
  );
    logic [10:0]                      sel;
    logic [soc_dbg_pkg::NR_HARTS-1:0] v;
    v   = '0;
    sel = ctrl[soc_dbg_pkg::DMCTRL_HARTSEL_LSB +: 11];
    // selectable: fc hart or one of the cluster cores
    if (ctrl[soc_dbg_pkg::DMCTRL_HALTREQ_BIT] && ctrl[soc_dbg_pkg::DMCTRL_DMACTIVE_BIT] &&
        sel[10:5] == soc_dbg_pkg::FC_CLUSTER_ID && !sel[4] && sel < soc_dbg_pkg::NR_HARTS &&
        (sel[3:0] == soc_dbg_pkg::FC_CORE_ID || sel[3:0] < soc_dbg_pkg::NB_CORES)) begin
      v[sel[3:0]] = 1'b1;
    end
    return v;
  endfunction

  // counted cycles exclude paused ones
  function automatic logic ref_wd_expired(input int unsigned idle_cycles);
    return idle_cycles >= soc_dbg_pkg::WD_TIMEOUT;
  endfunction

  // ***************************************************************************
  // compare tasks
  // ***************************************************************************

  task automatic check_word(input logic [soc_dbg_pkg::DATA_WIDTH-1:0] got,
                            input logic [soc_dbg_pkg::DATA_WIDTH-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t ns: %s is 0x%08h, expected 0x%08h", $time, what, got, exp);
    end
  endtask

  task automatic check_vec(input logic [soc_dbg_pkg::NR_HARTS-1:0] got,
                           input logic [soc_dbg_pkg::NR_HARTS-1:0] exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t ns: %s is 0x%04h, expected 0x%04h", $time, what, got, exp);
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("Error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic abort_on_timeout(input string what);
    $display("timeout at %0t ns, %s never arrived", $time, what);
    $display("CHECKS FAILED");
    $finish;
  endtask

  // between transfers the outputs must follow the model
  always @(negedge s_soc_clk) begin
    if (mon_en) begin
      check_vec(debug_req_o, ref_debug_req(dmctrl_m), "debug_req_o");
      check_flag(dmactive_o, dmctrl_m[soc_dbg_pkg::DMCTRL_DMACTIVE_BIT], "dmactive_o");
      check_flag(pready_o, 1'b0, "pready_o while idle");
    end
  end

  // ***************************************************************************
  // apb and reset helpers
  // ***************************************************************************

  // setup cycle, then access until pready_o, sampled mid cycle
  task automatic apb_xfer(input logic wr, input logic [soc_dbg_pkg::ADDR_WIDTH-1:0] addr,
                          input logic [soc_dbg_pkg::DATA_WIDTH-1:0] wdata);
    int unsigned                        n;
    logic                               ctrl_wr;
    logic [soc_dbg_pkg::DATA_WIDTH-1:0] old_ctrl;
    logic [soc_dbg_pkg::DATA_WIDTH-1:0] new_ctrl;
    ctrl_wr   = wr && addr == soc_dbg_pkg::ADDR_DMCONTROL;
    old_ctrl  = dmctrl_m;
    // only the defined control fields are kept
    new_ctrl  = ctrl_word(wdata[31], wdata[26:16], wdata[1], wdata[0]);
    mon_en    = 1'b0;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = wr;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge s_soc_clk);
    #2;
    penable_i = 1'b1;
    n = 0;
    while (n < 16) begin
      @(negedge s_soc_clk);
      n++;
      // control outputs move on the edge after the grant
      if (ctrl_wr) begin
        check_vec(debug_req_o, ref_debug_req((n == 1) ? old_ctrl : new_ctrl),
                  "debug_req_o around grant");
      end
      // ndmreset pulls the peripheral reset without a clock
      if (ctrl_wr && n == 2 && new_ctrl[soc_dbg_pkg::DMCTRL_NDMRESET_BIT]) begin
        check_flag(periph_rstn_o, 1'b0, "periph_rstn_o after ndmreset");
      end
      if (pready_o) begin
        break;
      end
    end
    if (!pready_o) begin
      abort_on_timeout("pready_o");
    end else begin
      check_flag(n == 2, 1'b1, "pready_o in second access cycle");
      if (!wr) begin
        check_word(prdata_o, ref_read(addr), "prdata_o");
      end else begin
        case (addr)
          soc_dbg_pkg::ADDR_DMCONTROL: dmctrl_m = new_ctrl;
          soc_dbg_pkg::ADDR_DATA0:     data0_m  = wdata;
          soc_dbg_pkg::ADDR_DATA1:     data1_m  = wdata;
          default:                     ;
        endcase
      end
      @(posedge s_soc_clk);
      #2;
      psel_i    = 1'b0;
      penable_i = 1'b0;
      mon_en    = 1'b1;
    end
  endtask

  // counts rising edges from the call, sampled just after each edge
  task automatic wait_periph_release(input int unsigned exp_edges);
    int unsigned n;
    n = 0;
    while (!periph_rstn_o && n < 8) begin
      @(posedge s_soc_clk);
      #2;
      n++;
    end
    if (!periph_rstn_o) begin
      abort_on_timeout("periph_rstn_o release");
    end else begin
      check_flag(n == exp_edges, 1'b1, "periph_rstn_o release edge count");
    end
  endtask

  // ***************************************************************************
  // test sequence
  // ***************************************************************************

  initial begin
    int unsigned n;
    void'($urandom(97));
    s_soc_rstn = 1'b0;
    paddr_i    = '0;
    pwdata_i   = '0;
    pwrite_i   = 1'b0;
    psel_i     = 1'b0;
    penable_i  = 1'b0;
    wd_kick_i  = 1'b1;
    mon_en     = 1'b0;
    dmctrl_m   = '0;
    data0_m    = '0;
    data1_m    = '0;
    n_checks   = 0;
    n_errors   = 0;
    repeat (16) @(posedge s_soc_clk);
    #2;
    // state while in reset
    check_flag(pready_o, 1'b0, "pready_o in reset");
    check_vec(debug_req_o, '0, "debug_req_o in reset");
    check_flag(dmactive_o, 1'b0, "dmactive_o in reset");
    check_flag(wd_expired_o, 1'b0, "wd_expired_o in reset");
    check_flag(periph_rstn_o, 1'b0, "periph_rstn_o in reset");
    s_soc_rstn = 1'b1;
    mon_en     = 1'b1;
    wait_periph_release(2);

    // scratch words, hartinfo, holes in the map
    for (int i = 0; i < 4; i++) begin
      apb_xfer(1'b1, soc_dbg_pkg::ADDR_DATA0, $urandom());
      apb_xfer(1'b1, soc_dbg_pkg::ADDR_DATA1, $urandom());
      apb_xfer(1'b0, soc_dbg_pkg::ADDR_DATA0, '0);
      apb_xfer(1'b0, soc_dbg_pkg::ADDR_DATA1, '0);
    end
    apb_xfer(1'b0, soc_dbg_pkg::ADDR_HARTINFO, '0);
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_HARTINFO, $urandom());
    apb_xfer(1'b0, soc_dbg_pkg::ADDR_HARTINFO, '0);
    apb_xfer(1'b1, 12'h010, $urandom());
    apb_xfer(1'b0, 12'h010, '0);
    apb_xfer(1'b0, 12'hFFC, '0);
    apb_xfer(1'b0, soc_dbg_pkg::ADDR_DATA0, '0);

    // halt requests
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b1, 11'h000, 1'b0, 1'b1));
    check_vec(debug_req_o, 16'h0001, "debug_req_o for hart 0");
    apb_xfer(1'b0, soc_dbg_pkg::ADDR_DMCONTROL, '0);
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b1, 11'h001, 1'b0, 1'b1));
    check_vec(debug_req_o, '0, "debug_req_o for hart 1");
    // cluster field 1
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b1, 11'h020, 1'b0, 1'b1));
    check_vec(debug_req_o, '0, "debug_req_o for cluster 1");
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b1, 11'h000, 1'b0, 1'b1));
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b1, 11'h000, 1'b0, 1'b0));
    check_vec(debug_req_o, '0, "debug_req_o with dmactive low");

    // non-debug-module reset
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b0, 11'h000, 1'b1, 1'b0));
    check_flag(periph_rstn_o, 1'b0, "periph_rstn_o during ndmreset");
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, '0);
    // the last edge of that transfer was the first of the two
    wait_periph_release(1);

    // watchdog holds during a debug session
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, ctrl_word(1'b1, 11'h000, 1'b0, 1'b1));
    wd_kick_i = 1'b0;
    for (int i = 0; i < 3 * soc_dbg_pkg::WD_TIMEOUT; i++) begin
      @(negedge s_soc_clk);
      check_flag(wd_expired_o, ref_wd_expired(0), "wd_expired_o while paused");
    end
    @(posedge s_soc_clk);
    #2;
    wd_kick_i = 1'b1;
    apb_xfer(1'b1, soc_dbg_pkg::ADDR_DMCONTROL, '0);
    // last kick, then count down
    wd_kick_i = 1'b0;
    n = 0;
    // n counts edges since the last kicked one
    while (!wd_expired_o && n < 4 * soc_dbg_pkg::WD_TIMEOUT) begin
      @(posedge s_soc_clk);
      #2;
      n++;
      check_flag(wd_expired_o, ref_wd_expired(n), "wd_expired_o countdown");
    end
    if (!wd_expired_o) begin
      abort_on_timeout("wd_expired_o");
    end else begin
      check_flag(periph_rstn_o, 1'b0, "periph_rstn_o after watchdog expiry");

      $display("checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("ALL CHECKS PASSED");
      end else begin
        $display("CHECKS FAILED");
      end
      $finish;
    end
  end

endmodule

`default_nettype wire

//--- filelist.f
src/soc_dbg_pkg.sv
src/per_bus_if.sv
src/apb_to_per.sv
src/dm_regs.sv
src/soc_watchdog.sv
src/soc_reset_ctrl.sv
src/soc_debug_domain.sv
verif/soc_debug_domain_asserts.sv
verif/tb_soc_debug_domain.sv

//--- Bender.yml
package:
  name: soc_debug_domain

sources:
  - src/soc_dbg_pkg.sv
  - src/per_bus_if.sv
  - src/apb_to_per.sv
  - src/dm_regs.sv
  - src/soc_watchdog.sv
  - src/soc_reset_ctrl.sv
  - src/soc_debug_domain.sv
  - target: test
    files:
      - verif/soc_debug_domain_asserts.sv
      - verif/tb_soc_debug_domain.sv
